//--- Makefile
# Verilator build and run for the virtual CSR unit.
# Example: make run SEED=7

VERILATOR ?= verilator
TOP       ?= vcsr_tb
SEED      ?= 95
VFLAGS    ?= -O3
BUILD_DIR ?= obj_dir
LOG       ?= run.log
FILELIST  := vcsr_top.f

BASE_FLAGS := --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(BASE_FLAGS) --top-module $(TOP) -GSeed=$(SEED) \
	  -Mdir $(BUILD_DIR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^NO ERRORS$$" $(LOG); then \
	  echo "Simulation passed, see $(LOG)"; \
	else \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/csr_file.sv
// Target CSRs at TargetBase. Responses follow one cycle later and misses are flagged illegal.
`timescale 1ns/1ps
`default_nettype none

module csr_file
  import csr_pkg::*;
#(
  parameter csr_addr_t   TargetBase  = 12'h300,
  parameter int unsigned TargetCount = 8
) (
  input  logic      clk,
  input  logic      rst_n,
  input  csr_req_t  treq,
  input  word       cfg_rdata,
  input  logic      cfg_hit,
  output csr_resp_t resp
);

  localparam int unsigned IdxW = (TargetCount > 1) ? $clog2(TargetCount) : 1;

  word             values [TargetCount];
  int unsigned     rel;
  logic            t_hit;
  logic [IdxW-1:0] idx;
  word             old_value;
  logic            valid_q;
  logic            t_hit_q;
  word             rdata_q;

  assign rel   = 32'(treq.addr) - 32'(TargetBase);
  assign t_hit = treq.enable && (treq.addr >= TargetBase) && (rel < TargetCount);
  assign idx   = rel[IdxW-1:0];

  for (genvar k = 0; k < TargetCount; k++) begin : gen_target
    csr_reg #(
      .Addr(csr_addr_t'(32'(TargetBase) + k))
    ) u_target_reg (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (treq),
      .value (values[k])
    );
  end

  always_comb begin
    old_value = '0;
    for (int k = 0; k < TargetCount; k++) begin
      if (t_hit && (int'(idx) == k)) begin
        old_value = values[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      t_hit_q <= 1'b0;
    end else begin
      valid_q <= treq.enable;
      t_hit_q <= t_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (t_hit) begin
      rdata_q <= old_value;
    end
  end

  // Configuration reads arrive from the bank on the same cycle as the response.
  always_comb begin
    resp.valid   = valid_q;
    resp.rdata   = cfg_hit ? cfg_rdata : rdata_q;
    resp.illegal = valid_q && !cfg_hit && !t_hit_q;
  end

  // Configuration and target addresses never overlap.
  a_single_source: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(cfg_hit && t_hit_q)
  );

  // A configuration hit is only possible as the answer to a request.
  a_cfg_hit_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    cfg_hit |-> resp.valid
  );

endmodule

`default_nettype wire

//--- hw/csr_pkg.sv
// Shared CSR types. Entry widths above 5 act as 5, and the entry pad bits are ignored.
`default_nettype none

package csr_pkg;

  typedef logic [31:0] word;
  typedef logic [11:0] csr_addr_t;
  typedef logic [4:0]  zimm_t;

  // Encodings follow the funct3 field of the SYSTEM opcode.
  typedef enum logic [2:0] {
    CSR_NONE = 3'b000,
    CSRRW    = 3'b001,
    CSRRS    = 3'b010,
    CSRRC    = 3'b011,
    CSRRWI   = 3'b101,
    CSRRSI   = 3'b110,
    CSRRCI   = 3'b111
  } csr_op_e;

  typedef struct packed {
    logic [11:0] pad;
    csr_addr_t   addr;
    logic [4:0]  offset;
    logic [2:0]  width;
  } vcsr_entry_t;

  // The configuration bank stores raw words and the remapper reads them as entries.
  typedef union packed {
    word         raw;
    vcsr_entry_t entry;
  } cfg_word_u;

  typedef struct packed {
    logic      enable;
    csr_addr_t addr;
    csr_op_e   op;
    zimm_t     zimm;
    word       data;
  } csr_req_t;

  typedef struct packed {
    logic valid;
    word  rdata;
    logic illegal;
  } csr_resp_t;

endpackage

`default_nettype wire

//--- hw/csr_reg.sv
// Single 32-bit CSR at address Addr. Immediate ops use the zero-extended zimm and CSRRS/CSRRC always write.
`timescale 1ns/1ps
`default_nettype none

module csr_reg
  import csr_pkg::*;
#(
  parameter csr_addr_t Addr = 12'h000
) (
  input  logic     clk,
  input  logic     rst_n,
  input  csr_req_t req,
  output word      value
);

  logic sel;
  word  operand;
  word  next_value;

  assign sel = req.enable && (req.addr == Addr);

  always_comb begin
    case (req.op)
      CSRRWI, CSRRSI, CSRRCI: operand = word'(req.zimm);
      default:                operand = req.data;
    endcase
  end

  always_comb begin
    case (req.op)
      CSRRW, CSRRWI: next_value = operand;
      CSRRS, CSRRSI: next_value = value | operand;
      CSRRC, CSRRCI: next_value = value & ~operand;
      default:       next_value = value;
    endcase
  end

  // The caller samples value in the request cycle, so it sees the old content.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value <= '0;
    end else if (sel) begin
      value <= next_value;
    end
  end

  // The core never issues an enabled request without an operation.
  a_op_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    req.enable |-> (req.op != CSR_NONE)
  );

endmodule

`default_nettype wire

//--- hw/vcsr_cfg.sv
// Configuration bank at VcsrBase. VcsrAmount must be a power of two and the old value returns one cycle later.
`timescale 1ns/1ps
`default_nettype none

module vcsr_cfg
  import csr_pkg::*;
#(
  parameter int unsigned VcsrAmount = 4,
  parameter csr_addr_t   VcsrBase   = 12'h100
) (
  input  logic      clk,
  input  logic      rst_n,
  input  csr_req_t  req,
  output cfg_word_u cfg [VcsrAmount],
  output word       cfg_rdata,
  output logic      cfg_hit
);

  localparam int unsigned IdxW = (VcsrAmount > 1) ? $clog2(VcsrAmount) : 1;

  word             values [VcsrAmount];
  int unsigned     rel;
  logic            hit;
  logic [IdxW-1:0] idx;
  word             old_value;

  assign rel = 32'(req.addr) - 32'(VcsrBase);
  assign hit = req.enable && (req.addr >= VcsrBase) && (rel < VcsrAmount);
  assign idx = rel[IdxW-1:0];

  for (genvar k = 0; k < VcsrAmount; k++) begin : gen_cfg
    csr_reg #(
      .Addr(csr_addr_t'(32'(VcsrBase) + k))
    ) u_cfg_reg (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (req),
      .value (values[k])
    );

    assign cfg[k].raw = values[k];
  end

  always_comb begin
    old_value = '0;
    for (int k = 0; k < VcsrAmount; k++) begin
      if (int'(idx) == k) begin
        old_value = values[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_hit <= 1'b0;
    end else begin
      cfg_hit <= hit;
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      cfg_rdata <= old_value;
    end
  end

endmodule

`default_nettype wire

//--- hw/vcsr_remap.sv
// Combinational virtual CSR rewrite at VcsrBase+VcsrAmount. Reads return the whole target word.
`timescale 1ns/1ps
`default_nettype none

module vcsr_remap
  import csr_pkg::*;
#(
  parameter int unsigned VcsrAmount = 4,
  parameter csr_addr_t   VcsrBase   = 12'h100
) (
  input  csr_req_t  req,
  input  cfg_word_u cfg [VcsrAmount],
  output csr_req_t  treq
);

  localparam int unsigned IdxW   = (VcsrAmount > 1) ? $clog2(VcsrAmount) : 1;
  localparam int unsigned VirtLo = 32'(VcsrBase) + VcsrAmount;
  localparam int unsigned VirtHi = VirtLo + VcsrAmount;

  logic            in_virt;
  int unsigned     rel;
  logic [IdxW-1:0] idx;
  vcsr_entry_t     entry;
  logic [2:0]      width;
  logic [5:0]      mask_full;
  zimm_t           mask;
  word             field;

  assign in_virt = (32'(req.addr) >= VirtLo) && (32'(req.addr) < VirtHi);
  assign rel     = 32'(req.addr) - VirtLo;
  assign idx     = rel[IdxW-1:0];
  assign entry   = cfg[idx].entry;

  // Only five immediate bits exist, so wider fields are clamped.
  assign width     = (entry.width > 3'd5) ? 3'd5 : entry.width;
  assign mask_full = (6'd1 << width) - 6'd1;
  assign mask      = mask_full[4:0];
  assign field     = word'(req.zimm & mask) << entry.offset;

  always_comb begin
    treq = req;
    if (in_virt) begin
      treq.addr = entry.addr;
      case (req.op)
        CSRRWI: begin
          treq.op   = CSRRW;
          treq.data = field;
        end
        CSRRSI: begin
          treq.op   = CSRRS;
          treq.data = field;
        end
        CSRRCI: begin
          treq.op   = CSRRC;
          treq.data = field;
        end
        default: begin
          treq.op   = req.op;
          treq.data = req.data;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/vcsr_top.sv
// CSR unit with virtual CSR remapping. There is no back-pressure and every request answers in the next cycle.
`timescale 1ns/1ps
`default_nettype none

module vcsr_top
  import csr_pkg::*;
#(
  parameter int unsigned VcsrAmount  = 4,
  parameter csr_addr_t   VcsrBase    = 12'h100,
  parameter csr_addr_t   TargetBase  = 12'h300,
  parameter int unsigned TargetCount = 8
) (
  input  logic      clk,
  input  logic      rst_n,
  input  csr_req_t  req,
  output csr_resp_t resp
);

  cfg_word_u cfg [VcsrAmount];
  word       cfg_rdata;
  logic      cfg_hit;
  csr_req_t  treq;

  vcsr_cfg #(
    .VcsrAmount (VcsrAmount),
    .VcsrBase   (VcsrBase)
  ) u_cfg (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .cfg       (cfg),
    .cfg_rdata (cfg_rdata),
    .cfg_hit   (cfg_hit)
  );

  vcsr_remap #(
    .VcsrAmount (VcsrAmount),
    .VcsrBase   (VcsrBase)
  ) u_remap (
    .req  (req),
    .cfg  (cfg),
    .treq (treq)
  );

  csr_file #(
    .TargetBase  (TargetBase),
    .TargetCount (TargetCount)
  ) u_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .treq      (treq),
    .cfg_rdata (cfg_rdata),
    .cfg_hit   (cfg_hit),
    .resp      (resp)
  );

endmodule

`default_nettype wire

//--- tb/vcsr_model.svh
// Reference model for the default top parameters. Virtual reads return the whole old target word.
`ifndef VCSR_MODEL_SVH
`define VCSR_MODEL_SVH

word cfg_model [VcsrAmount];
word tgt_model [TargetCount];

function automatic void clear_model();
  for (int k = 0; k < VcsrAmount; k++) begin
    cfg_model[k] = '0;
  end
  for (int k = 0; k < TargetCount; k++) begin
    tgt_model[k] = '0;
  end
endfunction

function automatic logic is_imm(input csr_op_e op);
  return op inside {CSRRWI, CSRRSI, CSRRCI};
endfunction

// Write, set and clear rules of a CSR instruction.
function automatic word apply_rule(input csr_op_e op, input word old, input word operand);
  case (op)
    CSRRW, CSRRWI: return operand;
    CSRRS, CSRRSI: return old | operand;
    CSRRC, CSRRCI: return old & ~operand;
    default:       return old;
  endcase
endfunction

// Returns the expected rd value and updates the model state.
function automatic void predict_access(input csr_op_e op, input int unsigned addr,
                                       input zimm_t zimm, input word data,
                                       output word rdata, output logic illegal);
  int unsigned taddr;
  int unsigned width;
  int unsigned offset;
  word         entry;
  word         operand;
  word         mask;
  rdata   = '0;
  illegal = 1'b0;
  taddr   = addr;
  operand = is_imm(op) ? word'(zimm) : data;
  if (addr >= VcsrBase && addr < VcsrBase + VcsrAmount) begin
    rdata = cfg_model[addr - VcsrBase];
    cfg_model[addr - VcsrBase] = apply_rule(op, rdata, operand);
  end else begin
    if (addr >= VcsrBase + VcsrAmount && addr < VcsrBase + 2 * VcsrAmount) begin
      // Entry layout: pad [31:20], target [19:8], offset [7:3], width [2:0].
      entry  = cfg_model[addr - VcsrBase - VcsrAmount];
      taddr  = 32'(entry[19:8]);
      offset = 32'(entry[7:3]);
      width  = 32'(entry[2:0]);
      if (width > 5) begin
        width = 5;
      end
      mask = (32'd1 << width) - 32'd1;
      if (is_imm(op)) begin
        operand = (word'(zimm) & mask) << offset;
      end
    end
    if (taddr >= TargetBase && taddr < TargetBase + TargetCount) begin
      rdata = tgt_model[taddr - TargetBase];
      tgt_model[taddr - TargetBase] = apply_rule(op, rdata, operand);
    end else begin
      illegal = 1'b1;
    end
  end
endfunction

`endif

//--- tb/vcsr_tb.sv
// Random test of vcsr_top with default parameters against a reference model; Seed picks the run.
`timescale 1ns/1ps
`default_nettype none

module vcsr_tb
  import csr_pkg::*;
#(
  parameter int unsigned Seed = 95
);

  localparam int unsigned VcsrAmount  = 4;
  localparam int unsigned VcsrBase    = 'h100;
  localparam int unsigned TargetBase  = 'h300;
  localparam int unsigned TargetCount = 8;

  localparam int unsigned ConfigOps  = 24;
  localparam int unsigned TargetOps  = 40;
  localparam int unsigned VirtImmOps = 40;
  localparam int unsigned VirtRegOps = 30;
  localparam int unsigned BadAddrOps = 10;
  localparam int unsigned BadVirtOps = 12;
  localparam int unsigned MixedOps   = 32;
  localparam int unsigned TotalRequests = ConfigOps + VcsrAmount + TargetOps + VirtImmOps
      + VirtRegOps + BadAddrOps + BadVirtOps + MixedOps + 2 * VcsrAmount + 2
      + 4 * TargetCount;
  localparam int unsigned CycleLimit = TotalRequests + 50;

  logic        clk;
  logic        rst_n;
  csr_req_t    req;
  csr_resp_t   resp;
  logic        exp_valid;
  word         exp_rdata;
  logic        exp_illegal;
  int unsigned errors;
  int unsigned checks;
  int unsigned requests;
  int unsigned cycles = 0;

  `include "vcsr_model.svh"

  vcsr_top #(
    .VcsrAmount  (VcsrAmount),
    .VcsrBase    (csr_addr_t'(VcsrBase)),
    .TargetBase  (csr_addr_t'(TargetBase)),
    .TargetCount (TargetCount)
  ) dut_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .resp  (resp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout: the test did not finish within %0d cycles", CycleLimit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic csr_op_e rand_reg_op();
    case ($urandom % 3)
      0:       return CSRRW;
      1:       return CSRRS;
      default: return CSRRC;
    endcase
  endfunction

  function automatic csr_op_e rand_imm_op();
    case ($urandom % 3)
      0:       return CSRRWI;
      1:       return CSRRSI;
      default: return CSRRCI;
    endcase
  endfunction

  function automatic csr_op_e rand_any_op();
    return ($urandom % 2 == 0) ? rand_reg_op() : rand_imm_op();
  endfunction

  function automatic csr_addr_t virt_addr(input int unsigned k);
    return csr_addr_t'(VcsrBase + VcsrAmount + k);
  endfunction

  function automatic csr_addr_t outside_addr();
    int unsigned a;
    do begin
      a = $urandom % 4096;
    end while ((a >= VcsrBase && a < VcsrBase + 2 * VcsrAmount) ||
               (a >= TargetBase && a < TargetBase + TargetCount));
    return csr_addr_t'(a);
  endfunction

  function automatic word make_entry(input int unsigned target, input int unsigned offset,
                                     input int unsigned width);
    return {12'($urandom), 12'(target), 5'(offset), 3'(width)};
  endfunction

  // Compares the response of the previous cycle, or its absence.
  task automatic check_response();
    checks++;
    assert (resp.valid == exp_valid) else begin
      errors++;
      $display("Error at %0t ns: resp.valid is %0b, expected %0b", $time, resp.valid, exp_valid);
    end
    if (exp_valid) begin
      assert (resp.illegal == exp_illegal) else begin
        errors++;
        $display("Error at %0t ns: resp.illegal is %0b, expected %0b",
                 $time, resp.illegal, exp_illegal);
      end
      if (!exp_illegal) begin
        assert (resp.rdata == exp_rdata) else begin
          errors++;
          $display("Error at %0t ns: resp.rdata is 0x%08h, expected 0x%08h",
                   $time, resp.rdata, exp_rdata);
        end
      end
    end else begin
      assert (!resp.illegal) else begin
        errors++;
        $display("Error at %0t ns: resp.illegal is 1, expected 0", $time);
      end
    end
  endtask

  task automatic send(input csr_op_e op, input csr_addr_t addr, input zimm_t zimm,
                      input word data);
    word  rd;
    logic ill;
    @(negedge clk);
    check_response();
    predict_access(op, 32'(addr), zimm, data, rd, ill);
    req.enable  = 1'b1;
    req.addr    = addr;
    req.op      = op;
    req.zimm    = zimm;
    req.data    = data;
    exp_valid   = 1'b1;
    exp_rdata   = rd;
    exp_illegal = ill;
    requests++;
  endtask

  task automatic idle();
    @(negedge clk);
    check_response();
    req       = '0;
    exp_valid = 1'b0;
  endtask

  task automatic read_targets();
    for (int k = 0; k < TargetCount; k++) begin
      send(CSRRS, csr_addr_t'(TargetBase + k), '0, '0);
    end
  endtask

  task automatic program_entry(input int unsigned k, input int unsigned target);
    send(CSRRW, csr_addr_t'(VcsrBase + k), '0, make_entry(target, $urandom % 28, $urandom % 8));
  endtask

  initial begin
    csr_addr_t a;
    void'($urandom(Seed));
    rst_n       = 1'b0;
    req         = '0;
    exp_valid   = 1'b0;
    exp_rdata   = '0;
    exp_illegal = 1'b0;
    errors      = 0;
    checks      = 0;
    requests    = 0;
    clear_model();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (3) idle();

    for (int i = 0; i < ConfigOps; i++) begin
      send(rand_reg_op(), csr_addr_t'(VcsrBase + $urandom % VcsrAmount), zimm_t'($urandom),
           $urandom);
    end
    for (int k = 0; k < VcsrAmount; k++) begin
      send(CSRRS, csr_addr_t'(VcsrBase + k), '0, '0);
    end

    for (int i = 0; i < TargetOps; i++) begin
      send(rand_any_op(), csr_addr_t'(TargetBase + $urandom % TargetCount), zimm_t'($urandom),
           $urandom);
    end
    read_targets();

    // All entries point into the target range here.
    for (int k = 0; k < VcsrAmount; k++) begin
      program_entry(k, TargetBase + $urandom % TargetCount);
    end
    for (int i = 0; i < VirtImmOps; i++) begin
      send(rand_imm_op(), virt_addr($urandom % VcsrAmount), zimm_t'($urandom), $urandom);
    end
    read_targets();

    for (int i = 0; i < VirtRegOps; i++) begin
      send(rand_reg_op(), virt_addr($urandom % VcsrAmount), zimm_t'($urandom), $urandom);
    end
    read_targets();

    for (int i = 0; i < BadAddrOps; i++) begin
      send(rand_any_op(), outside_addr(), zimm_t'($urandom), $urandom);
    end
    program_entry(0, TargetBase + TargetCount + $urandom % 16);
    program_entry(1, VcsrBase + $urandom % VcsrAmount);
    for (int i = 0; i < BadVirtOps; i++) begin
      send(rand_any_op(), virt_addr($urandom % VcsrAmount), zimm_t'($urandom), $urandom);
    end
    read_targets();

    // Mixed traffic with a gap after every fourth request.
    for (int i = 0; i < MixedOps; i++) begin
      case ($urandom % 4)
        0:       a = csr_addr_t'(VcsrBase + $urandom % VcsrAmount);
        1:       a = virt_addr($urandom % VcsrAmount);
        2:       a = csr_addr_t'(TargetBase + $urandom % TargetCount);
        default: a = outside_addr();
      endcase
      send(rand_any_op(), a, zimm_t'($urandom), $urandom);
      if (i % 4 == 3) begin
        idle();
      end
    end
    repeat (2) idle();

    $display("Done: %0d requests, %0d checks, %0d errors", requests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vcsr_top.f
+incdir+tb
hw/csr_pkg.sv
hw/csr_reg.sv
hw/vcsr_cfg.sv
hw/vcsr_remap.sv
hw/csr_file.sv
hw/vcsr_top.sv
tb/vcsr_tb.sv
